// ==== board_ctrl_regs.sv ====
// Board setting registers on the settings bus
// Drives clock-gen, SERDES, ADC and PHY pins, and selects the LED source
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_regs (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    set_stb_i,
   input  u2_ctrl_pkg::set_addr_t  set_addr_i,
   input  u2_ctrl_pkg::wb_data_t   set_data_i,
   input  logic                    run_tx_i,
   input  logic                    run_rx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_reset_n_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o
);

   u2_ctrl_pkg::ctrl_byte_t clock_q, serdes_q, adc_q, led_sw_q, phy_q, led_src_q;
   u2_ctrl_pkg::ctrl_byte_t led_hw;

   ////////////////////
   // Setting registers
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         led_sw_q  <= '0;
         phy_q     <= '0;
         led_src_q <= u2_ctrl_pkg::LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            u2_ctrl_pkg::SR_CLOCK:   clock_q   <= set_data_i[7:0];
            u2_ctrl_pkg::SR_SERDES:  serdes_q  <= set_data_i[7:0];
            u2_ctrl_pkg::SR_ADC:     adc_q     <= set_data_i[7:0];
            u2_ctrl_pkg::SR_LED_SW:  led_sw_q  <= set_data_i[7:0];
            u2_ctrl_pkg::SR_PHY:     phy_q     <= set_data_i[7:0];
            u2_ctrl_pkg::SR_LED_SRC: led_src_q <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   ////////////////////
   // Pin mapping
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_q[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_q[3:0];

   // Register holds the reset request, pin is active low
   assign phy_reset_n_o = ~phy_q[0];

   // Source bit 1 picks hardware status, 0 picks the software byte
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

// ==== pic.sv ====
// Programmable interrupt controller
// Mask, edge/level and polarity per line, pending bits cleared by writing 1s
`timescale 1ns/100ps
`default_nettype none

module pic (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  u2_ctrl_pkg::wb_addr_t wb_adr_i,
   input  u2_ctrl_pkg::wb_data_t wb_dat_i,
   input  u2_ctrl_pkg::irq_t     irq_i,
   output logic                  wb_ack_o,
   output u2_ctrl_pkg::wb_data_t wb_dat_o,
   output logic                  int_o
);

   u2_ctrl_pkg::irq_t mask_q, edge_q, pol_q, pend_q, act_q;
   u2_ctrl_pkg::irq_t act, set_bits, clr_bits;
   logic [2:0]        word_idx;
   logic              stb_q;
   logic              start;
   logic              wr_en;

   assign word_idx = wb_adr_i[4:2];
   assign start    = wb_stb_i & ~stb_q;

   // Writes land on the edge that ends the ack cycle
   assign wr_en = wb_stb_i & wb_we_i & wb_ack_o;

   ////////////////////
   // Line qualification
   assign act      = irq_i ^ pol_q;
   // Edge lines need an inactive-to-active step, level lines just active
   assign set_bits = act & ~(edge_q & act_q);
   assign clr_bits = (wr_en && word_idx == u2_ctrl_pkg::PIC_PEND) ?
                     wb_dat_i[u2_ctrl_pkg::IRQ_W-1:0] : '0;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         stb_q    <= 1'b0;
         wb_ack_o <= 1'b0;
         mask_q   <= '0;
         edge_q   <= '0;
         pol_q    <= '0;
         pend_q   <= '0;
         act_q    <= '0;
      end else begin
         stb_q    <= wb_stb_i;
         wb_ack_o <= start;
         act_q    <= act;
         // A new set beats a clear on the same edge
         pend_q   <= (pend_q & ~clr_bits) | set_bits;
         if (wr_en) begin
            case (word_idx)
               u2_ctrl_pkg::PIC_MASK: mask_q <= wb_dat_i[u2_ctrl_pkg::IRQ_W-1:0];
               u2_ctrl_pkg::PIC_EDGE: edge_q <= wb_dat_i[u2_ctrl_pkg::IRQ_W-1:0];
               u2_ctrl_pkg::PIC_POL:  pol_q  <= wb_dat_i[u2_ctrl_pkg::IRQ_W-1:0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // Read data, captured with the ack
   always_ff @(posedge wb_clk) begin
      if (start) begin
         wb_dat_o <= '0;
         case (word_idx)
            u2_ctrl_pkg::PIC_MASK: wb_dat_o[u2_ctrl_pkg::IRQ_W-1:0] <= mask_q;
            u2_ctrl_pkg::PIC_EDGE: wb_dat_o[u2_ctrl_pkg::IRQ_W-1:0] <= edge_q;
            u2_ctrl_pkg::PIC_POL:  wb_dat_o[u2_ctrl_pkg::IRQ_W-1:0] <= pol_q;
            u2_ctrl_pkg::PIC_PEND: wb_dat_o[u2_ctrl_pkg::IRQ_W-1:0] <= pend_q;
            u2_ctrl_pkg::PIC_LIVE: wb_dat_o[u2_ctrl_pkg::IRQ_W-1:0] <= irq_i;
            default: ;
         endcase
      end
   end

   assign int_o = |(pend_q & mask_q);

   // A pending bit only rises while its line was active
   assert property (@(posedge wb_clk) disable iff (wb_rst)
                    (pend_q & ~$past(pend_q) & ~$past(act)) == '0);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_u2_ctrl_core -f u2_ctrl_core.f &&
./obj_dir/Vtb_u2_ctrl_core | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== settings_bus.sv ====
// Settings bus slave
// Turns a Wishbone write into a one-cycle address/data strobe
`timescale 1ns/100ps
`default_nettype none

module settings_bus (
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  u2_ctrl_pkg::wb_addr_t  wb_adr_i,
   input  u2_ctrl_pkg::wb_data_t  wb_dat_i,
   output logic                   wb_ack_o,
   output logic                   set_stb_o,
   output u2_ctrl_pkg::set_addr_t set_addr_o,
   output u2_ctrl_pkg::wb_data_t  set_data_o
);

   logic stb_q;
   logic start;

   // First cycle of a strobe
   assign start = wb_stb_i & ~stb_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         stb_q     <= 1'b0;
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         stb_q     <= wb_stb_i;
         wb_ack_o  <= start;
         set_stb_o <= start & wb_we_i;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (start & wb_we_i) begin
         set_addr_o <= wb_adr_i[9:2];
         set_data_o <= wb_dat_i;
      end
   end

   assert property (@(posedge wb_clk) disable iff (wb_rst) set_stb_o |=> !set_stb_o);

endmodule

`default_nettype wire

// ==== status_readback.sv ====
// Readback slave for status words
// Sixteen-word mux with compatibility number and free-running cycle counter
`timescale 1ns/100ps
`default_nettype none

module status_readback (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  wb_stb_i,
   input  u2_ctrl_pkg::wb_addr_t wb_adr_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  u2_ctrl_pkg::irq_t     irq_i,
   output logic                  wb_ack_o,
   output u2_ctrl_pkg::wb_data_t wb_dat_o
);

   u2_ctrl_pkg::wb_data_t cycle_count;
   u2_ctrl_pkg::wb_data_t word;
   logic                  stb_q;
   logic                  start;

   assign start = wb_stb_i & ~stb_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
         stb_q       <= 1'b0;
         wb_ack_o    <= 1'b0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
         stb_q       <= wb_stb_i;
         wb_ack_o    <= start;
      end
   end

   // Word select on byte address bits 5 to 2
   always_comb begin
      case (wb_adr_i[5:2])
         u2_ctrl_pkg::RB_SIM_CLKDIV: word = {sim_mode_i, 27'd0, clock_divider_i};
         u2_ctrl_pkg::RB_COMPAT:     word = u2_ctrl_pkg::COMPAT_NUM;
         u2_ctrl_pkg::RB_IRQ:        word = {{(u2_ctrl_pkg::WB_DW - u2_ctrl_pkg::IRQ_W){1'b0}}, irq_i};
         u2_ctrl_pkg::RB_CYCLES:     word = cycle_count;
         default:                    word = '0;
      endcase
   end

   // Captured on the edge that raises ack
   always_ff @(posedge wb_clk) begin
      if (start)
         wb_dat_o <= word;
   end

endmodule

`default_nettype wire

// ==== tb_u2_ctrl_core.sv ====
// Testbench for the control plane core
// Random bus traffic checked against a register and interrupt model
`timescale 1ns/100ps
`default_nettype none

module tb_u2_ctrl_core;

   localparam int CLK_PERIOD    = 100;
   localparam int MAX_ACCESSES  = 400;
   localparam int ACCESS_CYCLES = 10;

   logic        wb_clk, wb_rst;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i, wb_dat_o;
   logic        wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o;
   logic        run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic [7:0]  irq_i, leds_o;
   logic        int_o, clock_ready_o, phy_reset_n_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;

   // Shadow copies of the setting and interrupt registers
   logic [7:0]  m_clock, m_serdes, m_adc, m_led_sw, m_phy, m_led_src;
   logic [7:0]  m_mask, m_edge, m_pol, m_pend, m_act_prev;
   logic        pic_wr_fire;
   logic [2:0]  pic_wr_idx;
   logic [7:0]  pic_wr_data, pend_snap;
   logic [31:0] rng_state;
   int          errors, accesses, ack_cycle;
   int          cycles = 0;

   u2_ctrl_core u_dut (.*);

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) cycles <= cycles + 1;

   ////////////////////
   // Interrupt model
   always @(posedge wb_clk) begin
      logic [7:0] act, set_bits, clr_bits;
      act = irq_i ^ m_pol;
      for (int i = 0; i < 8; i++)
         set_bits[i] = m_edge[i] ? (act[i] & ~m_act_prev[i]) : act[i];
      clr_bits = (pic_wr_fire && pic_wr_idx == 3'd3) ? pic_wr_data : 8'h00;
      if (wb_rst) begin
         m_mask     <= '0;
         m_edge     <= '0;
         m_pol      <= '0;
         m_pend     <= '0;
         m_act_prev <= '0;
      end else begin
         m_act_prev <= act;
         // Set wins over a clear on the same edge
         m_pend     <= (m_pend & ~clr_bits) | set_bits;
         if (pic_wr_fire) begin
            case (pic_wr_idx)
               3'd0: m_mask <= pic_wr_data;
               3'd1: m_edge <= pic_wr_data;
               3'd2: m_pol  <= pic_wr_data;
               default: ;
            endcase
         end
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [15:0] set_adr(input logic [7:0] num);
      return {u2_ctrl_pkg::SLAVE_SETTINGS, num, 2'b00};
   endfunction

   function automatic logic [15:0] rb_adr(input logic [3:0] word);
      return {u2_ctrl_pkg::SLAVE_READBACK, 4'd0, word, 2'b00};
   endfunction

   function automatic logic [15:0] pic_adr(input logic [2:0] word);
      return {u2_ctrl_pkg::SLAVE_PIC, 5'd0, word, 2'b00};
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_int();
      compare(32'(int_o), 32'(|(m_pend & m_mask)), "int_o");
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge wb_clk);
         check_int();
      end
   endtask

   // One access, held until ack and then released for a cycle
   task automatic bus_access(input logic [15:0] adr, input logic we,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      @(negedge wb_clk);
      check_int();
      wb_adr_i  = adr;
      wb_dat_i  = wdat;
      wb_we_i   = we;
      wb_stb_i  = 1'b1;
      wb_cyc_i  = 1'b1;
      pend_snap = m_pend;
      @(negedge wb_clk);
      check_int();
      while (!wb_ack_o) begin
         @(negedge wb_clk);
         check_int();
      end
      rdat      = wb_dat_o;
      ack_cycle = cycles;
      // PIC registers change on the edge that ends the ack cycle
      if (we && adr[15:10] == u2_ctrl_pkg::SLAVE_PIC) begin
         pic_wr_idx  = adr[4:2];
         pic_wr_data = wdat[7:0];
         pic_wr_fire = 1'b1;
      end
      @(negedge wb_clk);
      pic_wr_fire = 1'b0;
      wb_stb_i    = 1'b0;
      wb_cyc_i    = 1'b0;
      wb_we_i     = 1'b0;
      check_int();
      accesses++;
   endtask

   task automatic bus_write(input logic [15:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      bus_access(adr, 1'b1, wdat, unused);
   endtask

   task automatic bus_read(input logic [15:0] adr, output logic [31:0] rdat);
      bus_access(adr, 1'b0, 32'd0, rdat);
   endtask

   task automatic apply_setting(input logic [7:0] num, input logic [7:0] val);
      case (num)
         8'd0: m_clock   = val;
         8'd1: m_serdes  = val;
         8'd2: m_adc     = val;
         8'd3: m_led_sw  = val;
         8'd4: m_phy     = val;
         8'd8: m_led_src = val;
         default: ;
      endcase
   endtask

   task automatic drive_status(input logic [31:0] r);
      run_tx_i         = r[0];
      run_rx_i         = r[1];
      clk_status_i     = r[2];
      serdes_link_up_i = r[3];
      clock_divider_i  = r[7:4];
      sim_mode_i       = r[12];
   endtask

   task automatic check_pins();
      logic [7:0] hw, want_leds;
      hw    = 8'h00;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i;
      // Per LED, source bit set means hardware status
      for (int b = 0; b < 8; b++)
         want_leds[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      compare(32'(clock_ready_o), 32'(m_clock[4]), "clock_ready_o");
      compare(32'(clk_en_o), 32'(m_clock[3:2]), "clk_en_o");
      compare(32'(clk_sel_o), 32'(m_clock[1:0]), "clk_sel_o");
      compare(32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
              32'(m_serdes[3:0]), "serdes pins");
      compare(32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
              32'(m_adc[3:0]), "adc pins");
      compare(32'(phy_reset_n_o), 32'(!m_phy[0]), "phy_reset_n_o");
      compare(32'(leds_o), 32'(want_leds), "leds_o");
   endtask

   ////////////////////
   // Watchdog
   initial begin
      #(MAX_ACCESSES * ACCESS_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within the allowed time");
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      logic [31:0] r, d1, d2, want;
      int          c1;
      rng_state   = 32'h8841;
      errors      = 0;
      accesses    = 0;
      pic_wr_fire = 1'b0;
      pic_wr_idx  = '0;
      pic_wr_data = '0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      wb_we_i     = 1'b0;
      wb_stb_i    = 1'b0;
      wb_cyc_i    = 1'b0;
      irq_i       = '0;
      drive_status(next_rand());
      m_clock   = '0;
      m_serdes  = '0;
      m_adc     = '0;
      m_led_sw  = '0;
      m_phy     = '0;
      m_led_src = 8'h1E;
      wb_rst    = 1'b1;
      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;
      idle(1);

      // Reset values
      check_pins();
      compare(32'(wb_ack_o), 32'd0, "wb_ack_o after reset");
      compare(32'(int_o), 32'd0, "int_o after reset");

      // Random settings writes, unmapped numbers included
      for (int i = 0; i < 100; i++) begin
         r  = next_rand();
         d1 = next_rand();
         drive_status(r);
         bus_write(set_adr({4'd0, r[11:8]}), d1);
         apply_setting({4'd0, r[11:8]}, d1[7:0]);
         check_pins();
      end

      // LED source selection against changing status inputs
      for (int i = 0; i < 30; i++) begin
         r = next_rand();
         bus_write(set_adr(8'd8), {24'd0, r[15:8]});
         apply_setting(8'd8, r[15:8]);
         bus_write(set_adr(8'd3), {24'd0, r[23:16]});
         apply_setting(8'd3, r[23:16]);
         drive_status({24'd0, r[31:24]});
         idle(1);
         check_pins();
      end

      ////////////////////
      // Readback words
      for (int k = 0; k < 2; k++) begin
         r = next_rand();
         drive_status(r);
         irq_i = r[23:16];
         for (int w = 0; w < 15; w++) begin
            bus_read(rb_adr(4'(w)), d1);
            case (w)
               9: begin
                  want      = 32'd0;
                  want[31]  = sim_mode_i;
                  want[3:0] = clock_divider_i;
               end
               12:      want = 32'd4;
               13:      want = {24'd0, irq_i};
               default: want = 32'd0;
            endcase
            compare(d1, want, $sformatf("readback word %0d", w));
         end
         bus_read(rb_adr(4'd15), d1);
         c1 = ack_cycle;
         idle(int'(r[27:24]));
         bus_read(rb_adr(4'd15), d2);
         compare(d2 - d1, 32'(ack_cycle - c1), "cycle counter step");
      end

      ////////////////////
      // Interrupt controller
      for (int k = 0; k < 6; k++) begin
         r = next_rand();
         bus_write(pic_adr(3'd0), {24'd0, r[7:0]});
         bus_write(pic_adr(3'd1), {24'd0, r[15:8]});
         bus_write(pic_adr(3'd2), {24'd0, r[23:16]});
         bus_read(pic_adr(3'd0), d1);
         compare(d1, {24'd0, m_mask}, "pic mask");
         for (int s = 0; s < 10; s++) begin
            r     = next_rand();
            irq_i = r[7:0];
            idle(int'(r[9:8]));
            bus_read(pic_adr(3'd3), d1);
            compare(d1, {24'd0, pend_snap}, "pic pending");
            if (r[10])
               bus_write(pic_adr(3'd3), {24'd0, r[31:24]});
            if (r[11]) begin
               bus_read(pic_adr(3'd4), d1);
               compare(d1, {24'd0, irq_i}, "pic live lines");
            end
         end
      end

      $display("Run complete: %0d accesses, %0d errors", accesses, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== u2_ctrl_core.f ====
u2_ctrl_pkg.sv
wb_slave_decode.sv
settings_bus.sv
board_ctrl_regs.sv
status_readback.sv
pic.sv
u2_ctrl_core.sv
tb_u2_ctrl_core.sv

// ==== u2_ctrl_core.sv ====
// Control plane of the radio core in the wb_clk domain
// Decoder plus settings, board registers, readback and interrupt slaves
`timescale 1ns/100ps
`default_nettype none

module u2_ctrl_core (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   // Wishbone slave port
   input  u2_ctrl_pkg::wb_addr_t   wb_adr_i,
   input  u2_ctrl_pkg::wb_data_t   wb_dat_i,
   input  logic                    wb_we_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_cyc_i,
   output u2_ctrl_pkg::wb_data_t   wb_dat_o,
   output logic                    wb_ack_o,
   // Status and interrupt inputs
   input  logic                    run_tx_i,
   input  logic                    run_rx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    sim_mode_i,
   input  logic [3:0]              clock_divider_i,
   input  u2_ctrl_pkg::irq_t       irq_i,
   output logic                    int_o,
   // Board control pins
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_reset_n_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o
);

   logic                   rb_stb, set_stb_wb, pic_stb;
   logic                   rb_ack, set_ack, pic_ack;
   u2_ctrl_pkg::wb_data_t  rb_dat, pic_dat;
   logic                   set_stb;
   u2_ctrl_pkg::set_addr_t set_addr;
   u2_ctrl_pkg::wb_data_t  set_data;

   ////////////////////
   // Interconnect
   wb_slave_decode u_decode (
      .wb_adr_i(wb_adr_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .rb_ack_i(rb_ack), .set_ack_i(set_ack), .pic_ack_i(pic_ack),
      .rb_dat_i(rb_dat), .pic_dat_i(pic_dat),
      .rb_stb_o(rb_stb), .set_stb_o(set_stb_wb), .pic_stb_o(pic_stb),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o));

   ////////////////////
   // Settings bus, slave 7
   settings_bus u_settings_bus (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_stb_i(set_stb_wb), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   board_ctrl_regs u_board_regs (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   ////////////////////
   // Readback, slave 5
   status_readback u_readback (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_stb_i(rb_stb), .wb_adr_i(wb_adr_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i), .irq_i(irq_i),
      .wb_ack_o(rb_ack), .wb_dat_o(rb_dat));

   ////////////////////
   // Interrupt controller, slave 8
   pic u_pic (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_stb_i(pic_stb), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .irq_i(irq_i),
      .wb_ack_o(pic_ack), .wb_dat_o(pic_dat), .int_o(int_o));

endmodule

`default_nettype wire

// ==== u2_ctrl_pkg.sv ====
// Shared definitions for the wb_clk control plane
// Address map, settings numbers, widths, reset values and types
`default_nettype none

package u2_ctrl_pkg;

   ////////////////////
   // Bus shape
   localparam int WB_DW = 32;
   localparam int WB_AW = 16;

   typedef logic [WB_DW-1:0] wb_data_t;
   typedef logic [WB_AW-1:0] wb_addr_t;

   ////////////////////
   // Slave prefixes on the top address bits
   localparam int DECODE_W = 6;
   localparam logic [DECODE_W-1:0] SLAVE_READBACK = 6'b110011;  // 0xCC00
   localparam logic [DECODE_W-1:0] SLAVE_SETTINGS = 6'b110101;  // 0xD400
   localparam logic [DECODE_W-1:0] SLAVE_PIC      = 6'b110110;  // 0xD800

   // Settings register number, byte address bits 9 to 2
   typedef logic [7:0] set_addr_t;
   typedef logic [7:0] ctrl_byte_t;

   ////////////////////
   // Board setting registers
   localparam set_addr_t SR_CLOCK   = 8'd0;
   localparam set_addr_t SR_SERDES  = 8'd1;
   localparam set_addr_t SR_ADC     = 8'd2;
   localparam set_addr_t SR_LED_SW  = 8'd3;
   localparam set_addr_t SR_PHY     = 8'd4;
   localparam set_addr_t SR_LED_SRC = 8'd8;

   // Hardware drives LEDs 4 to 1 out of reset
   localparam ctrl_byte_t LED_SRC_RESET = 8'h1E;

   ////////////////////
   // Readback and interrupts
   localparam wb_data_t COMPAT_NUM = 32'd4;
   localparam int IRQ_W = 8;
   typedef logic [IRQ_W-1:0] irq_t;

   // Readback word numbers
   localparam logic [3:0] RB_SIM_CLKDIV = 4'd9;
   localparam logic [3:0] RB_COMPAT     = 4'd12;
   localparam logic [3:0] RB_IRQ        = 4'd13;
   localparam logic [3:0] RB_CYCLES     = 4'd15;

   // Interrupt controller word numbers
   localparam logic [2:0] PIC_MASK = 3'd0;
   localparam logic [2:0] PIC_EDGE = 3'd1;
   localparam logic [2:0] PIC_POL  = 3'd2;
   localparam logic [2:0] PIC_PEND = 3'd3;
   localparam logic [2:0] PIC_LIVE = 3'd4;

endpackage

`default_nettype wire

// ==== wb_slave_decode.sv ====
// Single-master Wishbone decoder for the three control slaves
// Gates the strobe by address prefix and merges acks and read data
`timescale 1ns/100ps
`default_nettype none

module wb_slave_decode (
   input  u2_ctrl_pkg::wb_addr_t wb_adr_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   input  logic                  rb_ack_i,
   input  logic                  set_ack_i,
   input  logic                  pic_ack_i,
   input  u2_ctrl_pkg::wb_data_t rb_dat_i,
   input  u2_ctrl_pkg::wb_data_t pic_dat_i,
   output logic                  rb_stb_o,
   output logic                  set_stb_o,
   output logic                  pic_stb_o,
   output logic                  wb_ack_o,
   output u2_ctrl_pkg::wb_data_t wb_dat_o
);

   logic [u2_ctrl_pkg::DECODE_W-1:0] prefix;
   logic                             access;

   assign prefix = wb_adr_i[u2_ctrl_pkg::WB_AW-1 -: u2_ctrl_pkg::DECODE_W];
   assign access = wb_stb_i & wb_cyc_i;

   // Unmapped prefixes get no strobe and so no ack
   assign rb_stb_o  = access & (prefix == u2_ctrl_pkg::SLAVE_READBACK);
   assign set_stb_o = access & (prefix == u2_ctrl_pkg::SLAVE_SETTINGS);
   assign pic_stb_o = access & (prefix == u2_ctrl_pkg::SLAVE_PIC);

   assign wb_ack_o = rb_ack_i | set_ack_i | pic_ack_i;

   // Settings slave reads back as zero
   always_comb begin
      case (prefix)
         u2_ctrl_pkg::SLAVE_READBACK: wb_dat_o = rb_dat_i;
         u2_ctrl_pkg::SLAVE_PIC:      wb_dat_o = pic_dat_i;
         default:                     wb_dat_o = '0;
      endcase
   end

   // Each access is answered by one slave only
   always_comb begin
      assert ($onehot0({rb_ack_i, set_ack_i, pic_ack_i}))
         else $error("more than one slave ack active");
   end

endmodule

`default_nettype wire
